//--- hdl/neuron_array.sv
`timescale 1ns/1ps

module neuron_array #(
  parameter snn_cfg_pkg::pot_t THRESHOLD = 16'sd100
) (
  input  logic                     clk,
  input  logic                     rst,
  spike_event_if.sink              ev,
  neuron_spike_if.source           spk,
  input  logic                     wt_wr_en,
  input  snn_cfg_pkg::in_idx_t     wt_wr_row,
  input  snn_cfg_pkg::neuron_idx_t wt_wr_neuron,
  input  snn_cfg_pkg::weight_t     wt_wr_data
);

  localparam int N = snn_cfg_pkg::LAYER_SIZE;

  snn_ctrl_pkg::neuron_state_t state;
  snn_cfg_pkg::pot_t           pot [N];
  snn_cfg_pkg::weight_t        row [N];
  snn_cfg_pkg::out_spike_t     fire_vec;
  logic                        rd_en;
  logic                        rd_vld;        // Row read, add pending
  logic                        frame_last_q;
  logic                        ev_fire;
  logic                        spk_fire;

  weight_mem u_weight_mem (
    .clk       (clk),
    .rst       (rst),
    .wr_en     (wt_wr_en),
    .wr_row    (wt_wr_row),
    .wr_neuron (wt_wr_neuron),
    .wr_data   (wt_wr_data),
    .rd_en     (rd_en),
    .rd_row    (ev.idx),
    .rd_data   (row)
  );

  assign ev.ready = (state == snn_ctrl_pkg::RUN);
  assign ev_fire  = ev.valid && ev.ready;
  assign rd_en    = ev_fire && !ev.step_end;

  // Integrate-and-fire compare
  always_comb begin
    for (int n = 0; n < N; n++) begin
      fire_vec[n] = (pot[n] >= THRESHOLD);
    end
  end

  assign spk.valid      = (state == snn_ctrl_pkg::FIRE);
  assign spk.spikes     = fire_vec;
  assign spk.frame_last = frame_last_q;
  assign spk_fire       = spk.valid && spk.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= snn_ctrl_pkg::RUN;
      rd_vld       <= 1'b0;
      frame_last_q <= 1'b0;
    end else begin
      rd_vld <= rd_en;
      case (state)
        snn_ctrl_pkg::RUN: begin
          if (ev_fire && ev.step_end) begin
            state        <= snn_ctrl_pkg::DRAIN;
            frame_last_q <= ev.frame_last;
          end
        end
        snn_ctrl_pkg::DRAIN: begin
          if (!rd_vld) begin
            state <= snn_ctrl_pkg::FIRE;
          end
        end
        snn_ctrl_pkg::FIRE: begin
          if (spk_fire) begin
            state <= snn_ctrl_pkg::RUN;
          end
        end
        default: state <= snn_ctrl_pkg::RUN;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int n = 0; n < N; n++) begin
        pot[n] <= '0;
      end
    end else if (rd_vld) begin
      for (int n = 0; n < N; n++) begin
        pot[n] <= pot[n] + snn_cfg_pkg::pot_t'(row[n]);  // Sign extended
      end
    end else if (spk_fire) begin
      for (int n = 0; n < N; n++) begin
        if (frame_last_q || fire_vec[n]) begin
          pot[n] <= '0;  // Fired or frame done
        end
      end
    end
  end

endmodule

//--- hdl/snn_cfg_pkg.sv
package snn_cfg_pkg;

  // Layer geometry
  localparam int IN_SIZE        = 16;
  localparam int LAYER_SIZE     = 8;
  localparam int MAX_TIME_STEPS = 8;

  localparam int IN_IDX_W     = $clog2(IN_SIZE);
  localparam int NEURON_IDX_W = $clog2(LAYER_SIZE);
  localparam int STEP_W       = $clog2(MAX_TIME_STEPS);
  localparam int COUNT_W      = $clog2(MAX_TIME_STEPS) + 1;

  localparam int WEIGHT_W = 8;
  localparam int POT_W    = 16;

  // Bit i is input neuron i
  typedef logic [IN_SIZE-1:0] in_spike_t;

  // Event index and weight row select
  typedef logic [IN_IDX_W-1:0] in_idx_t;

  typedef logic [NEURON_IDX_W-1:0] neuron_idx_t;

  typedef logic [LAYER_SIZE-1:0] out_spike_t;

  typedef logic signed [WEIGHT_W-1:0] weight_t;

  // Wide enough for IN_SIZE max weights plus threshold
  typedef logic signed [POT_W-1:0] pot_t;

  typedef logic [STEP_W-1:0] step_t;

  // Spikes per neuron within one frame
  typedef logic [COUNT_W-1:0] count_t;

endpackage

//--- hdl/snn_ctrl_pkg.sv
package snn_ctrl_pkg;

  // Input train decoder
  typedef enum logic [1:0] {
    IDLE,
    SCAN,   // One event per set bit
    MARK    // End-of-step marker
  } decode_state_t;

  // Neuron array
  typedef enum logic [1:0] {
    RUN,    // Accepting events
    DRAIN,  // Weight pipeline emptying
    FIRE    // Spike vector presented
  } neuron_state_t;

endpackage

//--- hdl/snn_fc_top.sv
`timescale 1ns/1ps

module snn_fc_top #(
  parameter int                TIME_STEPS = 4,
  parameter snn_cfg_pkg::pot_t THRESHOLD  = 16'sd100
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  snn_cfg_pkg::in_spike_t   in_spikes,
  input  logic                     wt_wr_en,
  input  snn_cfg_pkg::in_idx_t     wt_wr_row,
  input  snn_cfg_pkg::neuron_idx_t wt_wr_neuron,
  input  snn_cfg_pkg::weight_t     wt_wr_data,
  output logic                     out_valid,
  input  logic                     out_ready,
  output snn_cfg_pkg::out_spike_t  out_spikes,
  output logic                     out_frame_last,
  output snn_cfg_pkg::neuron_idx_t out_class
);

  spike_event_if  ev_if ();
  neuron_spike_if spk_if ();

  spike_event_decoder #(
    .TIME_STEPS (TIME_STEPS)
  ) u_decoder (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_spikes (in_spikes),
    .ev        (ev_if)
  );

  neuron_array #(
    .THRESHOLD (THRESHOLD)
  ) u_neuron_array (
    .clk          (clk),
    .rst          (rst),
    .ev           (ev_if),
    .spk          (spk_if),
    .wt_wr_en     (wt_wr_en),
    .wt_wr_row    (wt_wr_row),
    .wt_wr_neuron (wt_wr_neuron),
    .wt_wr_data   (wt_wr_data)
  );

  spike_result_buffer u_result_buffer (
    .clk            (clk),
    .rst            (rst),
    .spk            (spk_if),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_spikes     (out_spikes),
    .out_frame_last (out_frame_last),
    .out_class      (out_class)
  );

endmodule

//--- hdl/snn_if.sv
`timescale 1ns/1ps

// Decoder to neuron array
interface spike_event_if;
  logic                 valid;
  logic                 ready;
  snn_cfg_pkg::in_idx_t idx;
  logic                 step_end;    // Marker, idx not used
  logic                 frame_last;  // Only with step_end

  modport source (
    output valid,
    input  ready,
    output idx,
    output step_end,
    output frame_last
  );

  modport sink (
    input  valid,
    output ready,
    input  idx,
    input  step_end,
    input  frame_last
  );
endinterface

// Neuron array to result buffer
interface neuron_spike_if;
  logic                    valid;
  logic                    ready;
  snn_cfg_pkg::out_spike_t spikes;
  logic                    frame_last;

  modport source (
    output valid,
    input  ready,
    output spikes,
    output frame_last
  );

  modport sink (
    input  valid,
    output ready,
    input  spikes,
    input  frame_last
  );
endinterface

//--- hdl/spike_event_decoder.sv
`timescale 1ns/1ps

module spike_event_decoder #(
  parameter int TIME_STEPS = 4
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  snn_cfg_pkg::in_spike_t in_spikes,
  spike_event_if.source          ev
);

  snn_ctrl_pkg::decode_state_t state;
  snn_cfg_pkg::in_spike_t      pend;      // Spikes not yet issued
  snn_cfg_pkg::in_spike_t      pend_clr;
  snn_cfg_pkg::step_t          step;
  logic                        last_step;
  logic                        in_fire;
  logic                        ev_fire;

  // Priority encoder, lowest set bit wins
  function automatic snn_cfg_pkg::in_idx_t lowest_set(input snn_cfg_pkg::in_spike_t v);
    snn_cfg_pkg::in_idx_t idx;
    idx = '0;
    for (int i = snn_cfg_pkg::IN_SIZE - 1; i >= 0; i--) begin
      if (v[i]) begin
        idx = snn_cfg_pkg::in_idx_t'(i);
      end
    end
    return idx;
  endfunction

  assign in_ready  = (state == snn_ctrl_pkg::IDLE);
  assign in_fire   = in_valid && in_ready;
  assign ev_fire   = ev.valid && ev.ready;
  assign pend_clr  = pend & (pend - snn_cfg_pkg::in_spike_t'(1));  // Drop lowest set bit
  assign last_step = (step == snn_cfg_pkg::step_t'(TIME_STEPS - 1));

  assign ev.valid      = (state != snn_ctrl_pkg::IDLE);
  assign ev.idx        = lowest_set(pend);
  assign ev.step_end   = (state == snn_ctrl_pkg::MARK);
  assign ev.frame_last = ev.step_end && last_step;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= snn_ctrl_pkg::IDLE;
      step  <= '0;
    end else begin
      case (state)
        snn_ctrl_pkg::IDLE: begin
          if (in_fire) begin
            state <= (in_spikes == '0) ? snn_ctrl_pkg::MARK : snn_ctrl_pkg::SCAN;
          end
        end
        snn_ctrl_pkg::SCAN: begin
          if (ev_fire && pend_clr == '0) begin
            state <= snn_ctrl_pkg::MARK;
          end
        end
        snn_ctrl_pkg::MARK: begin
          if (ev_fire) begin
            state <= snn_ctrl_pkg::IDLE;
            step  <= last_step ? '0 : step + snn_cfg_pkg::step_t'(1);  // Wrap at frame end
          end
        end
        default: state <= snn_ctrl_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      pend <= in_spikes;
    end else if (ev_fire && state == snn_ctrl_pkg::SCAN) begin
      pend <= pend_clr;
    end
  end

endmodule

//--- hdl/spike_result_buffer.sv
`timescale 1ns/1ps

module spike_result_buffer (
  input  logic                     clk,
  input  logic                     rst,
  neuron_spike_if.sink             spk,
  output logic                     out_valid,
  input  logic                     out_ready,
  output snn_cfg_pkg::out_spike_t  out_spikes,
  output logic                     out_frame_last,
  output snn_cfg_pkg::neuron_idx_t out_class
);

  localparam int N = snn_cfg_pkg::LAYER_SIZE;

  snn_cfg_pkg::count_t      cnt [N];
  snn_cfg_pkg::count_t      cnt_nxt [N];   // Including this vector
  snn_cfg_pkg::count_t      best_cnt;
  snn_cfg_pkg::neuron_idx_t best;
  logic                     spk_fire;

  assign spk.ready = !out_valid || out_ready;
  assign spk_fire  = spk.valid && spk.ready;

  always_comb begin
    for (int n = 0; n < N; n++) begin
      cnt_nxt[n] = cnt[n] + snn_cfg_pkg::count_t'(spk.spikes[n]);
    end
  end

  // Strict compare keeps the lowest index on a tie
  always_comb begin
    best     = '0;
    best_cnt = cnt_nxt[0];
    for (int n = 1; n < N; n++) begin
      if (cnt_nxt[n] > best_cnt) begin
        best     = snn_cfg_pkg::neuron_idx_t'(n);
        best_cnt = cnt_nxt[n];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int n = 0; n < N; n++) begin
        cnt[n] <= '0;
      end
    end else if (spk_fire) begin
      for (int n = 0; n < N; n++) begin
        cnt[n] <= spk.frame_last ? '0 : cnt_nxt[n];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (spk_fire) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (spk_fire) begin
      out_spikes     <= spk.spikes;
      out_frame_last <= spk.frame_last;
      out_class      <= best;  // Valid with frame_last only
    end
  end

endmodule

//--- hdl/weight_mem.sv
`timescale 1ns/1ps

module weight_mem (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wr_en,
  input  snn_cfg_pkg::in_idx_t     wr_row,
  input  snn_cfg_pkg::neuron_idx_t wr_neuron,
  input  snn_cfg_pkg::weight_t     wr_data,
  input  logic                     rd_en,
  input  snn_cfg_pkg::in_idx_t     rd_row,
  output snn_cfg_pkg::weight_t     rd_data [snn_cfg_pkg::LAYER_SIZE]
);

  // One row per input neuron
  snn_cfg_pkg::weight_t mem [snn_cfg_pkg::IN_SIZE][snn_cfg_pkg::LAYER_SIZE];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < snn_cfg_pkg::IN_SIZE; r++) begin
        for (int n = 0; n < snn_cfg_pkg::LAYER_SIZE; n++) begin
          mem[r][n] <= '0;
        end
      end
    end else if (wr_en) begin
      mem[wr_row][wr_neuron] <= wr_data;  // Single element
    end
  end

  // Whole row, one cycle after rd_en
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_row];
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing -f vlog.f --top-module snn_fc_tb -o snn_fc_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/snn_fc_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Finished with errors" "$log"; then
  echo "Simulation FAILED"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

echo "Simulation PASSED"
exit 0

//--- tb/snn_fc_stimulus.txt
// 1RN000WW weight write (row R, neuron N, weight WW), 2000SSSS input spike train
// 3LC000VV expected output (L frame last, C class, VV spike vector)
20000001
30000000
2000FFFF
30000000
20000000
30000000
20008020
31000000
// Weights loaded between frames
10000064 10100032 102000EC 1110003C
1120003C 11300064 12200028 12400078
1500009C 1550007F 1F70001E
20000004
30000010
20000003
3000000B
20000021
30000020
20000006
3110001E
20000002
30000008
20008000
30000000
20008000
30000000
20008002
3130000E
// New frame, residual of neuron 7 gone
20008000
30000000

//--- tb/snn_fc_checks.svh
`ifndef SNN_FC_CHECKS_SVH
`define SNN_FC_CHECKS_SVH

// Spike vector of one time step
task automatic check_spikes(input snn_cfg_pkg::out_spike_t got,
                            input snn_cfg_pkg::out_spike_t want);
  if (got !== want) begin
    stop_on_error($sformatf("Fail at %0t: out_spikes %b, expected %b", $time, got, want));
  end
endtask

// Winning neuron at a frame end
task automatic check_class(input snn_cfg_pkg::neuron_idx_t got,
                           input snn_cfg_pkg::neuron_idx_t want);
  if (got !== want) begin
    stop_on_error($sformatf("Fail at %0t: out_class %0d, expected %0d", $time, got, want));
  end
endtask

task automatic check_frame_last(input logic got, input logic want);
  if (got !== want) begin
    stop_on_error($sformatf("Fail at %0t: out_frame_last %b, expected %b",
                            $time, got, want));
  end
endtask

`endif

//--- tb/snn_fc_tb.sv
`timescale 1ns/1ps

module snn_fc_tb;

  localparam int DEPTH = 64;

  logic                     clk;
  logic                     rst;
  logic                     in_valid;
  logic                     in_ready;
  snn_cfg_pkg::in_spike_t   in_spikes;
  logic                     wt_wr_en;
  snn_cfg_pkg::in_idx_t     wt_wr_row;
  snn_cfg_pkg::neuron_idx_t wt_wr_neuron;
  snn_cfg_pkg::weight_t     wt_wr_data;
  logic                     out_valid;
  logic                     out_ready;
  snn_cfg_pkg::out_spike_t  out_spikes;
  logic                     out_frame_last;
  snn_cfg_pkg::neuron_idx_t out_class;

  logic [31:0] stim [DEPTH];
  logic [31:0] ops [$];       // Weight writes and trains, file order
  int          op_gate [$];   // Outputs seen before the op may start
  logic [31:0] expected [$];
  int          n_seen;
  int          n_steps;
  int          n_weights;
  logic        loaded;

  snn_fc_top #(
    .TIME_STEPS (4),
    .THRESHOLD  (16'sd100)
  ) u_snn_fc_top (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .in_spikes      (in_spikes),
    .wt_wr_en       (wt_wr_en),
    .wt_wr_row      (wt_wr_row),
    .wt_wr_neuron   (wt_wr_neuron),
    .wt_wr_data     (wt_wr_data),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_spikes     (out_spikes),
    .out_frame_last (out_frame_last),
    .out_class      (out_class)
  );

  always #5 clk = ~clk;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped");
  endtask

  `include "snn_fc_checks.svh"

  task automatic read_stimulus();
    int n_exp;
    n_exp     = 0;
    n_steps   = 0;
    n_weights = 0;
    foreach (stim[i]) begin
      stim[i] = '0;
    end
    $readmemh("tb/snn_fc_stimulus.txt", stim);
    foreach (stim[i]) begin
      case (stim[i][31:28])
        4'h1: begin
          ops.push_back(stim[i]);
          op_gate.push_back(n_exp);
          n_weights++;
        end
        4'h2: begin
          ops.push_back(stim[i]);
          op_gate.push_back(n_exp);
          n_steps++;
        end
        4'h3: begin
          expected.push_back(stim[i]);
          n_exp++;
        end
        default: ;
      endcase
    end
  endtask

  task automatic write_weight(input logic [31:0] rec, input int gate);
    wait (n_seen >= gate);  // Previous frame fully out
    @(negedge clk);
    wt_wr_en     = 1'b1;
    wt_wr_row    = snn_cfg_pkg::in_idx_t'(rec[27:24]);
    wt_wr_neuron = snn_cfg_pkg::neuron_idx_t'(rec[22:20]);
    wt_wr_data   = snn_cfg_pkg::weight_t'(rec[7:0]);
    @(negedge clk);
    wt_wr_en = 1'b0;
  endtask

  task automatic send_train(input logic [31:0] rec);
    int gap;
    gap = $urandom % 4;
    repeat (gap) @(negedge clk);
    @(negedge clk);
    in_valid  = 1'b1;
    in_spikes = snn_cfg_pkg::in_spike_t'(rec[15:0]);
    while (!in_ready) @(negedge clk);
    @(negedge clk);  // Accepted on the edge in between
    in_valid  = 1'b0;
    in_spikes = '0;
  endtask

  // Called when a transfer happens on the coming edge
  task automatic check_output();
    logic [31:0] want;
    if (n_seen >= expected.size()) begin
      stop_on_error($sformatf("Fail at %0t: output with no expected value left", $time));
    end else begin
      want = expected[n_seen];
      check_spikes(out_spikes, snn_cfg_pkg::out_spike_t'(want[7:0]));
      check_frame_last(out_frame_last, want[24]);
      if (want[24]) begin
        check_class(out_class, snn_cfg_pkg::neuron_idx_t'(want[22:20]));
      end
      n_seen++;
    end
  endtask

  initial begin
    void'($urandom(5667));
    $timeformat(-9, 0, " ns", 0);
    clk          = 1'b0;
    rst          = 1'b1;
    in_valid     = 1'b0;
    in_spikes    = '0;
    wt_wr_en     = 1'b0;
    wt_wr_row    = '0;
    wt_wr_neuron = '0;
    wt_wr_data   = '0;
    n_seen       = 0;
    loaded       = 1'b0;
    read_stimulus();
    if (ops.size() == 0 || expected.size() == 0) begin
      stop_on_error("Stimulus file is missing or holds no trains and expected outputs");
    end
    loaded = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    if (!in_ready || out_valid) begin
      stop_on_error($sformatf("Fail at %0t: in_ready %b, out_valid %b after reset",
                              $time, in_ready, out_valid));
    end
    foreach (ops[i]) begin
      if (ops[i][31:28] == 4'h1) begin
        write_weight(ops[i], op_gate[i]);
      end else begin
        send_train(ops[i]);
      end
    end
    wait (n_seen == expected.size());
    repeat (20) @(negedge clk);  // Catch any extra output
    $display("Finished with no errors");
    $finish;
  end

  // Output side with random stalls
  initial begin
    out_ready = 1'b0;
    wait (loaded);
    forever begin
      @(negedge clk);
      out_ready = ($urandom % 4) != 0;
      if (!rst && out_valid && out_ready) begin
        check_output();
      end
    end
  end

  initial begin
    int limit;
    wait (loaded);
    limit = 8 + 4 * n_weights + 200 * n_steps;
    repeat (limit) @(posedge clk);
    stop_on_error($sformatf("Timeout: run did not finish within %0d cycles", limit));
  end

endmodule

//--- vlog.f
+incdir+tb
hdl/snn_cfg_pkg.sv
hdl/snn_ctrl_pkg.sv
hdl/snn_if.sv
hdl/weight_mem.sv
hdl/spike_event_decoder.sv
hdl/neuron_array.sv
hdl/spike_result_buffer.sv
hdl/snn_fc_top.sv
tb/snn_fc_tb.sv
